// ==== sram_subsys.f ====
src/sram_pkg.sv
src/sram_if.sv
src/burst_addr_gen.sv
src/wb2sram.sv
src/sram_sp.sv
src/sram_subsys.sv
tests/sram_subsys_sva.sv
tests/tb_sram_subsys.sv

// ==== Makefile ====
TOP = tb_sram_subsys
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sram_subsys.f -o $(TOP)

run: compile
	@./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q ">>> FAIL" $(LOG); then echo "Test failed, see $(LOG)"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi; \
	echo "Test passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/tb_sram_subsys.sv ====
// Simulation top that drives the SRAM subsystem from a cycle table and checks each beat
`timescale 1ns/100ps

module tb_sram_subsys;
  import sram_pkg::*;

  logic          ahb3_clk_i;
  logic          rst_n_i;
  logic [AW-1:0] ahb3_haddr_i;
  bte_e          ahb3_htrans_i;
  cti_e          ahb3_hburst_i;
  logic          ahb3_hmastlock_i;
  logic [DW-1:0] ahb3_hwdata_i;
  logic [SW-1:0] ahb3_hprot_i;
  logic          ahb3_hsel_i;
  logic          ahb3_hwrite_i;
  logic          ahb3_hready_o;
  logic          ahb3_hresp_o;
  logic [DW-1:0] ahb3_hrdata_o;

  // Stimulus table with one entry per bus cycle
  string         row_name[$];
  logic          row_write[$];
  cti_e          row_cti[$];
  bte_e          row_bte[$];
  logic [AW-1:0] row_addr[$];
  int            row_beats[$];
  logic [SW-1:0] row_sel[$];
  // Beat sent once with a wrong address or -1 for none
  int            row_bad[$];

  // Mirror of the RAM contents
  logic [DW-1:0] ref_mem [0:(1 << MEM_AW)-1];

  integer seed;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;

  sram_subsys sram_subsys_inst (
    .ahb3_clk_i       (ahb3_clk_i),
    .rst_n_i          (rst_n_i),
    .ahb3_haddr_i     (ahb3_haddr_i),
    .ahb3_htrans_i    (ahb3_htrans_i),
    .ahb3_hburst_i    (ahb3_hburst_i),
    .ahb3_hmastlock_i (ahb3_hmastlock_i),
    .ahb3_hwdata_i    (ahb3_hwdata_i),
    .ahb3_hprot_i     (ahb3_hprot_i),
    .ahb3_hsel_i      (ahb3_hsel_i),
    .ahb3_hwrite_i    (ahb3_hwrite_i),
    .ahb3_hready_o    (ahb3_hready_o),
    .ahb3_hresp_o     (ahb3_hresp_o),
    .ahb3_hrdata_o    (ahb3_hrdata_o)
  );

  // 100 ns clock
  initial begin
    ahb3_clk_i = 1'b0;
    forever #50 ahb3_clk_i = ~ahb3_clk_i;
  end

  // Run limit armed once the table length is known
  initial begin
    while (cycle_limit == 0 || cycle_cnt <= cycle_limit) begin
      @(posedge ahb3_clk_i);
      cycle_cnt++;
    end
    $display("Timeout: bus handshake did not complete within %0d cycles", cycle_limit);
    $display(">>> FAIL");
    $fatal(1, "Simulation timed out");
  end

  task automatic check_equal(input string name, input logic [DW-1:0] expected,
                             input logic [DW-1:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  task automatic add_row(input string name, input logic write, input cti_e cti,
                         input bte_e bte, input logic [AW-1:0] addr, input int beats,
                         input logic [SW-1:0] sel, input int bad);
    row_name.push_back(name);
    row_write.push_back(write);
    row_cti.push_back(cti);
    row_bte.push_back(bte);
    row_addr.push_back(addr);
    row_beats.push_back(beats);
    row_sel.push_back(sel);
    row_bad.push_back(bad);
  endtask

  task automatic build_table();
    // Name, write, cycle type, burst type, byte address, beats, selects, bad beat
    add_row("classic_wr",    1'b1, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0040, 1, 4'hf, -1);
    add_row("classic_rd",    1'b0, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0040, 1, 4'hf, -1);
    add_row("partial_wr",    1'b1, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0040, 1, 4'h5, -1);
    add_row("partial_rd",    1'b0, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0040, 1, 4'hf, -1);
    add_row("incr8_wr",      1'b1, CTI_INCR,    BTE_LINEAR, 32'h0000_0100, 8, 4'hf, -1);
    add_row("incr8_rd",      1'b0, CTI_INCR,    BTE_LINEAR, 32'h0000_0100, 8, 4'hf, -1);
    // Word offset 2 of an aligned 4-word block
    add_row("wrap4_wr",      1'b1, CTI_INCR,    BTE_WRAP4,  32'h0000_0208, 4, 4'hf, -1);
    add_row("wrap4_rd",      1'b0, CTI_INCR,    BTE_WRAP4,  32'h0000_0208, 4, 4'hf, -1);
    add_row("wrap8_wr",      1'b1, CTI_INCR,    BTE_WRAP8,  32'h0000_0414, 8, 4'hf, -1);
    add_row("wrap8_rd",      1'b0, CTI_INCR,    BTE_WRAP8,  32'h0000_0414, 8, 4'hf, -1);
    add_row("wrap16_wr",     1'b1, CTI_INCR,    BTE_WRAP16, 32'h0000_0538, 16, 4'hf, -1);
    add_row("wrap16_rd",     1'b0, CTI_INCR,    BTE_WRAP16, 32'h0000_0538, 16, 4'hf, -1);
    add_row("const3_wr",     1'b1, CTI_CONST,   BTE_LINEAR, 32'h0000_0600, 3, 4'hf, -1);
    add_row("const3_rd",     1'b0, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0600, 1, 4'hf, -1);
    // Target of the bad beat gets a known value first
    add_row("err_target_wr", 1'b1, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0708, 1, 4'hf, -1);
    add_row("err_burst_wr",  1'b1, CTI_INCR,    BTE_LINEAR, 32'h0000_0300, 4, 4'hf, 2);
    add_row("err_target_rd", 1'b0, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0708, 1, 4'hf, -1);
    add_row("err_burst_rd",  1'b0, CTI_INCR,    BTE_LINEAR, 32'h0000_0300, 4, 4'hf, -1);
  endtask

  // Byte address of a beat wrapping inside its aligned block
  function automatic logic [AW-1:0] beat_addr(input logic [AW-1:0] start, input cti_e cti,
                                              input bte_e bte, input int beat);
    logic [WORD_AW-1:0] word;
    logic [WORD_AW-1:0] mask;
    word = start[AW-1:BYTE_AW];
    if (cti == CTI_INCR) begin
      case (bte)
        BTE_WRAP4:  mask = 'h3;
        BTE_WRAP8:  mask = 'h7;
        BTE_WRAP16: mask = 'hf;
        default:    mask = '1;
      endcase
      word = (word & ~mask) | ((word + beat[WORD_AW-1:0]) & mask);
    end
    return {word, {BYTE_AW{1'b0}}};
  endfunction

  task automatic update_ref(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                            input logic [SW-1:0] sel);
    logic [MEM_AW-1:0] idx;
    idx = addr[BYTE_AW +: MEM_AW];
    for (int b = 0; b < SW; b++) begin
      if (sel[b]) begin
        ref_mem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic drive_beat(input logic [AW-1:0] addr, input cti_e cti, input bte_e bte,
                            input logic write, input logic [DW-1:0] data,
                            input logic [SW-1:0] sel);
    @(posedge ahb3_clk_i);
    ahb3_haddr_i     <= addr;
    ahb3_hburst_i    <= cti;
    ahb3_htrans_i    <= bte;
    ahb3_hwrite_i    <= write;
    ahb3_hwdata_i    <= data;
    ahb3_hprot_i     <= sel;
    ahb3_hmastlock_i <= 1'b1;
    ahb3_hsel_i      <= 1'b1;
  endtask

  // Counts the clocks without a response before the beat ends
  task automatic wait_beat_end(output int waits);
    waits = 0;
    @(negedge ahb3_clk_i);
    while (!ahb3_hready_o && !ahb3_hresp_o) begin
      waits++;
      @(negedge ahb3_clk_i);
    end
  endtask

  task automatic bus_idle();
    @(posedge ahb3_clk_i);
    ahb3_hmastlock_i <= 1'b0;
    ahb3_hsel_i      <= 1'b0;
    ahb3_hburst_i    <= CTI_CLASSIC;
  endtask

  task automatic run_row(input int r);
    int                beat;
    int                waits;
    logic              bad_done;
    logic              send_bad;
    cti_e              cti;
    logic [AW-1:0]     addr;
    logic [AW-1:0]     bus_addr;
    logic [DW-1:0]     data;
    logic [MEM_AW-1:0] idx;
    beat = 0;
    bad_done = 1'b0;
    while (beat < row_beats[r]) begin
      addr = beat_addr(row_addr[r], row_cti[r], row_bte[r], beat);
      idx = addr[BYTE_AW +: MEM_AW];
      send_bad = (beat == row_bad[r]) && !bad_done;
      // Wrong address lands 256 words away
      bus_addr = send_bad ? (addr ^ 32'h0000_0400) : addr;
      if (row_cti[r] == CTI_CLASSIC) begin
        cti = CTI_CLASSIC;
      end else if (beat == row_beats[r] - 1) begin
        cti = CTI_END;
      end else begin
        cti = row_cti[r];
      end
      data = $random(seed);
      drive_beat(bus_addr, cti, row_bte[r], row_write[r], data, row_sel[r]);
      wait_beat_end(waits);
      // First beat waits one clock and later beats none
      check_equal({row_name[r], " wait cycles"}, (beat == 0) ? 1 : 0, waits);
      // hresp in bit 1 and hready in bit 0
      check_equal({row_name[r], " response"}, send_bad ? 2 : 1,
                  {ahb3_hresp_o, ahb3_hready_o});
      if (send_bad) begin
        // Retry the same beat at the predicted address
        bad_done = 1'b1;
      end else begin
        if (row_write[r]) begin
          update_ref(addr, data, row_sel[r]);
        end else begin
          check_equal({row_name[r], " read data"}, ref_mem[idx], ahb3_hrdata_o);
        end
        beat++;
      end
    end
  endtask

  initial begin
    int total_beats;
    seed = 51156;
    rst_n_i          <= 1'b0;
    ahb3_haddr_i     <= '0;
    ahb3_htrans_i    <= BTE_LINEAR;
    ahb3_hburst_i    <= CTI_CLASSIC;
    ahb3_hmastlock_i <= 1'b0;
    ahb3_hwdata_i    <= '0;
    ahb3_hprot_i     <= '0;
    ahb3_hsel_i      <= 1'b0;
    ahb3_hwrite_i    <= 1'b0;
    build_table();
    total_beats = 0;
    foreach (row_beats[i]) begin
      total_beats += row_beats[i];
    end
    // Four clocks per beat plus reset and idle slack
    cycle_limit = total_beats * 4 + 50;

    repeat (8) @(posedge ahb3_clk_i);
    rst_n_i <= 1'b1;

    // Bus stays quiet until the first strobe
    repeat (2) begin
      @(negedge ahb3_clk_i);
      check_equal("idle hready", 0, ahb3_hready_o);
      check_equal("idle hresp", 0, ahb3_hresp_o);
    end

    for (int r = 0; r < row_name.size(); r++) begin
      run_row(r);
      bus_idle();
    end
    @(negedge ahb3_clk_i);

    if (sram_subsys_inst.sram_subsys_sva_inst.assert_fails != 0) begin
      $display("Protocol assertions failed %0d times",
               sram_subsys_inst.sram_subsys_sva_inst.assert_fails);
      $display(">>> FAIL");
      $fatal(1, "Stopping on protocol assertion failures");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== tests/sram_subsys_sva.sv ====
// Bus protocol assertions on the SRAM subsystem ports, attached to the top level by bind
`timescale 1ns/100ps

module sram_subsys_sva (
  input logic ahb3_clk_i,
  input logic rst_n_i,
  input logic ahb3_hmastlock_i,
  input logic ahb3_hsel_i,
  input logic ahb3_hready_i,
  input logic ahb3_hresp_i
);

  // Number of failed assertions so far
  int unsigned assert_fails = 0;

  // Cycle strobe and slave strobe together
  logic strobe;
  assign strobe = ahb3_hmastlock_i & ahb3_hsel_i;

  // Ack and error never in the same cycle
  ready_resp_excl: assert property (@(posedge ahb3_clk_i) !(ahb3_hready_i && ahb3_hresp_i))
    else begin
      assert_fails++;
      $error("hready and hresp are high in the same cycle");
    end

  // No response outside a strobed cycle
  resp_needs_strobe: assert property (@(posedge ahb3_clk_i)
    (ahb3_hready_i || ahb3_hresp_i) |-> strobe)
    else begin
      assert_fails++;
      $error("hready or hresp is high without the bus strobe");
    end

  // Quiet bus while reset is held
  quiet_in_reset: assert property (@(posedge ahb3_clk_i)
    !rst_n_i |-> (!ahb3_hready_i && !ahb3_hresp_i))
    else begin
      assert_fails++;
      $error("hready or hresp is high during reset");
    end

endmodule

bind sram_subsys sram_subsys_sva sram_subsys_sva_inst (
  .ahb3_clk_i       (ahb3_clk_i),
  .rst_n_i          (rst_n_i),
  .ahb3_hmastlock_i (ahb3_hmastlock_i),
  .ahb3_hsel_i      (ahb3_hsel_i),
  .ahb3_hready_i    (ahb3_hready_o),
  .ahb3_hresp_i     (ahb3_hresp_o)
);

// ==== src/sram_subsys.sv ====
// Top level of the bus-attached SRAM, wires the bridge, burst tracker and RAM together
`timescale 1ns/100ps

module sram_subsys (
  input  logic                    ahb3_clk_i,
  input  logic                    rst_n_i,
  input  logic [sram_pkg::AW-1:0] ahb3_haddr_i,
  input  sram_pkg::bte_e          ahb3_htrans_i,
  input  sram_pkg::cti_e          ahb3_hburst_i,
  input  logic                    ahb3_hmastlock_i,
  input  logic [sram_pkg::DW-1:0] ahb3_hwdata_i,
  input  logic [sram_pkg::SW-1:0] ahb3_hprot_i,
  input  logic                    ahb3_hsel_i,
  input  logic                    ahb3_hwrite_i,
  output logic                    ahb3_hready_o,
  output logic                    ahb3_hresp_o,
  output logic [sram_pkg::DW-1:0] ahb3_hrdata_o
);
  import sram_pkg::*;

  // Lookahead read address and registered write address
  logic [WORD_AW-1:0] rd_addr;
  logic [WORD_AW-1:0] wr_addr;
  // Burst address mismatch
  logic               addr_err;

  // Bridge to RAM port
  sram_if #(.MEM_AW(MEM_AW)) sram_bus ();

  // Acked beats advance the burst prediction
  burst_addr_gen burst_addr_gen_inst (
    .ahb3_clk_i  (ahb3_clk_i),
    .rst_n_i     (rst_n_i),
    .word_addr_i (ahb3_haddr_i[AW-1:BYTE_AW]),
    .cti_i       (ahb3_hburst_i),
    .bte_i       (ahb3_htrans_i),
    .hsel_i      (ahb3_hsel_i),
    .hmastlock_i (ahb3_hmastlock_i),
    .beat_ack_i  (ahb3_hready_o),
    .rd_addr_o   (rd_addr),
    .wr_addr_o   (wr_addr),
    .addr_err_o  (addr_err)
  );

  wb2sram wb2sram_inst (
    .ahb3_clk_i       (ahb3_clk_i),
    .rst_n_i          (rst_n_i),
    .ahb3_hburst_i    (ahb3_hburst_i),
    .ahb3_hmastlock_i (ahb3_hmastlock_i),
    .ahb3_hwdata_i    (ahb3_hwdata_i),
    .ahb3_hprot_i     (ahb3_hprot_i),
    .ahb3_hsel_i      (ahb3_hsel_i),
    .ahb3_hwrite_i    (ahb3_hwrite_i),
    .rd_addr_i        (rd_addr),
    .wr_addr_i        (wr_addr),
    .addr_err_i       (addr_err),
    .ahb3_hready_o    (ahb3_hready_o),
    .ahb3_hresp_o     (ahb3_hresp_o),
    .ahb3_hrdata_o    (ahb3_hrdata_o),
    .mem_bus          (sram_bus.bridge)
  );

  sram_sp #(.MEM_AW(MEM_AW)) sram_sp_inst (
    .clk_i   (ahb3_clk_i),
    .mem_bus (sram_bus.mem)
  );

endmodule

// ==== src/sram_sp.sv ====
// Single-port on-chip RAM with byte lane writes and a registered read port
`timescale 1ns/100ps

module sram_sp #(
  parameter int MEM_AW = sram_pkg::MEM_AW
) (
  input  logic clk_i,
  sram_if.mem  mem_bus
);
  import sram_pkg::*;

  // Number of words in the array
  localparam int DEPTH = 1 << MEM_AW;

  // Storage, contents undefined after power up
  logic [DW-1:0] ram_q [0:DEPTH-1];

  // Byte lane writes
  always_ff @(posedge clk_i) begin
    if (mem_bus.we) begin
      for (int b = 0; b < SW; b++) begin
        // Unselected lanes keep their old bytes
        if (mem_bus.sel[b]) begin
          ram_q[mem_bus.waddr][8*b +: 8] <= mem_bus.din[8*b +: 8];
        end
      end
    end
  end

  // Read every clock, old data on a same-address write
  always_ff @(posedge clk_i) begin
    mem_bus.dout <= ram_q[mem_bus.waddr];
  end

endmodule

// ==== src/wb2sram.sv ====
// Bus bridge, generates acknowledge and error and drives the RAM port
`timescale 1ns/100ps

module wb2sram (
  input  logic                         ahb3_clk_i,
  input  logic                         rst_n_i,
  input  sram_pkg::cti_e               ahb3_hburst_i,
  input  logic                         ahb3_hmastlock_i,
  input  logic [sram_pkg::DW-1:0]      ahb3_hwdata_i,
  input  logic [sram_pkg::SW-1:0]      ahb3_hprot_i,
  input  logic                         ahb3_hsel_i,
  input  logic                         ahb3_hwrite_i,
  input  logic [sram_pkg::WORD_AW-1:0] rd_addr_i,
  input  logic [sram_pkg::WORD_AW-1:0] wr_addr_i,
  input  logic                         addr_err_i,
  output logic                         ahb3_hready_o,
  output logic                         ahb3_hresp_o,
  output logic [sram_pkg::DW-1:0]      ahb3_hrdata_o,
  sram_if.bridge                       mem_bus
);
  import sram_pkg::*;

  // Cycle and slave strobe together
  logic cyc_active;
  // Registered acknowledge, one clock behind the strobe
  logic ack_q;
  logic nxt_ack;

  assign cyc_active = ahb3_hmastlock_i & ahb3_hsel_i;

  // Next acknowledge by cycle type
  always_comb begin
    nxt_ack = 1'b0;
    if (cyc_active) begin
      case (ahb3_hburst_i)
        // Single beats alternate, so a held strobe
        // gets a fresh access every second clock
        CTI_CLASSIC: nxt_ack = ~ack_q;
        CTI_END:     nxt_ack = ~ack_q;
        // Burst beats ack back to back
        CTI_CONST:   nxt_ack = 1'b1;
        CTI_INCR:    nxt_ack = 1'b1;
        default:     nxt_ack = 1'b0;
      endcase
    end
  end

  always_ff @(posedge ahb3_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= nxt_ack;
    end
  end

  // Wrong burst address turns the ack into an error
  assign ahb3_hready_o = ack_q & cyc_active & ~addr_err_i;
  assign ahb3_hresp_o  = ack_q & cyc_active & addr_err_i;

  // Only acked write beats reach the array
  assign mem_bus.we = ahb3_hwrite_i & ahb3_hready_o;

  // Writes use the registered beat address
  // Reads use the lookahead address
  always_comb begin
    if (ahb3_hwrite_i) begin
      mem_bus.waddr = wr_addr_i[MEM_AW-1:0];
    end else begin
      mem_bus.waddr = rd_addr_i[MEM_AW-1:0];
    end
  end

  // Data and lanes pass straight to the RAM
  assign mem_bus.din = ahb3_hwdata_i;
  assign mem_bus.sel = ahb3_hprot_i;

  // RAM output register feeds the bus
  assign ahb3_hrdata_o = mem_bus.dout;

endmodule

// ==== src/burst_addr_gen.sv ====
// Burst tracker for the bus bridge that predicts the word address of each beat and flags a mismatch
`timescale 1ns/100ps

module burst_addr_gen (
  input  logic                         ahb3_clk_i,
  input  logic                         rst_n_i,
  input  logic [sram_pkg::WORD_AW-1:0] word_addr_i,
  input  sram_pkg::cti_e               cti_i,
  input  sram_pkg::bte_e               bte_i,
  input  logic                         hsel_i,
  input  logic                         hmastlock_i,
  input  logic                         beat_ack_i,
  output logic [sram_pkg::WORD_AW-1:0] rd_addr_o,
  output logic [sram_pkg::WORD_AW-1:0] wr_addr_o,
  output logic                         addr_err_o
);
  import sram_pkg::*;

  // Cycle strobe and slave strobe both up
  logic               cyc_active;
  // Registered feedback burst in progress
  logic               burst_q;
  logic               burst_start;
  logic               burst_stop;
  // Cycle and burst type of the previous clock
  cti_e               cti_q;
  bte_e               bte_q;
  // Address used last cycle and predicted for this beat
  logic [WORD_AW-1:0] addr_q;
  logic [WORD_AW-1:0] nxt_addr;

  assign cyc_active = hmastlock_i & hsel_i;

  // Constant or incrementing cycle opens a burst
  assign burst_start = cyc_active & ~burst_q &
                       ((cti_i == CTI_CONST) || (cti_i == CTI_INCR));

  // Acked end beat closes it
  assign burst_stop = burst_q & hsel_i & beat_ack_i & (cti_i == CTI_END);

  always_ff @(posedge ahb3_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      burst_q <= 1'b0;
      cti_q   <= CTI_CLASSIC;
      bte_q   <= BTE_LINEAR;
    end else begin
      cti_q <= cti_i;
      bte_q <= bte_i;
      if (burst_start) begin
        burst_q <= 1'b1;
      end else if (burst_stop) begin
        burst_q <= 1'b0;
      end
    end
  end

  // Address for the RAM this cycle
  always_comb begin
    nxt_addr = addr_q;
    if (burst_q) begin
      // Step only after an acked incrementing beat
      // Constant bursts and stalled beats keep the address
      if ((cti_q == CTI_INCR) && beat_ack_i) begin
        case (bte_q)
          BTE_WRAP4:  nxt_addr[1:0] = addr_q[1:0] + 2'd1;
          BTE_WRAP8:  nxt_addr[2:0] = addr_q[2:0] + 3'd1;
          BTE_WRAP16: nxt_addr[3:0] = addr_q[3:0] + 4'd1;
          default:    nxt_addr      = addr_q + 1'b1;
        endcase
      end
    end else if (cyc_active) begin
      // Classic beat or first burst beat takes the bus address
      nxt_addr = word_addr_i;
    end
  end

  // Last used word address
  always_ff @(posedge ahb3_clk_i) begin
    addr_q <= nxt_addr;
  end

  // Read port looks one beat ahead
  assign rd_addr_o = nxt_addr;

  // Write lands where the acked beat was addressed
  assign wr_addr_o = addr_q;

  // Master left the predicted path
  assign addr_err_o = burst_q & (addr_q != word_addr_i);

endmodule

// ==== src/sram_if.sv ====
// Memory port between the bus bridge and the RAM, with a modport for each side
`timescale 1ns/100ps

interface sram_if #(
  parameter int MEM_AW = sram_pkg::MEM_AW
);
  import sram_pkg::*;

  // Write strobe, one cycle per stored beat
  logic              we;
  // Shared read/write word address
  logic [MEM_AW-1:0] waddr;
  // Write data and byte lane enables
  logic [DW-1:0]     din;
  logic [SW-1:0]     sel;
  // Registered read data
  logic [DW-1:0]     dout;

  // Bridge side drives the request
  modport bridge (
    output we, waddr, din, sel,
    input  dout
  );

  // RAM side answers with read data
  modport mem (
    input  we, waddr, din, sel,
    output dout
  );

endinterface

// ==== src/sram_pkg.sv ====
// Shared bus widths, memory depth and cycle/burst encodings, imported by every design file
package sram_pkg;

  // Bus data width in bits
  localparam int DW = 32;

  // Byte address width
  localparam int AW = 32;

  // One select bit per byte lane
  localparam int SW = DW / 8;

  // Byte offset within a 32-bit word
  localparam int BYTE_AW = 2;

  // Word part of the byte address
  localparam int WORD_AW = AW - BYTE_AW;

  // On-chip RAM depth, 1024 words
  // Higher word address bits alias onto this range
  localparam int MEM_AW = 10;

  // Cycle type on the bus
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_CONST   = 3'b001,
    CTI_INCR    = 3'b010,
    CTI_END     = 3'b111
  } cti_e;

  // Burst type, sets the wrap boundary of incrementing bursts
  typedef enum logic [1:0] {
    BTE_LINEAR = 2'b00,
    BTE_WRAP4  = 2'b01,
    BTE_WRAP8  = 2'b10,
    BTE_WRAP16 = 2'b11
  } bte_e;

endpackage
